/* mmu_pkg.sv */
package mmu_pkg;

  localparam int WORD_W = 32;
  localparam int VPN_W  = 4;
  localparam int OFFS_W = 6;
  localparam int VA_W   = 2 * VPN_W + OFFS_W;
  localparam int PPN_W  = 4;
  localparam int PA_W   = PPN_W + OFFS_W;

  typedef enum logic [1:0] {
    e_priv_u = 2'b00,
    e_priv_s = 2'b01,
    e_priv_m = 2'b11
  } priv_e;

  typedef struct packed {
    logic [VPN_W-1:0]  vpn1;
    logic [VPN_W-1:0]  vpn0;
    logic [OFFS_W-1:0] offs;
  } vaddr_t;

  // Page table entry as stored in memory
  typedef struct packed {
    logic             valid;
    logic             read;
    logic             write;
    logic             user;
    logic             dirty;
    logic [PPN_W-1:0] ppn;
    logic [WORD_W-PPN_W-6:0] pad;
  } pte_t;

  typedef struct packed {
    logic [2*VPN_W-1:0] tag;
    logic [PPN_W-1:0]   ppn;
    logic               user;
    logic               write;
    logic               dirty;
  } tlb_entry_t;

  // Memory word seen as data or as a PTE
  typedef union packed {
    logic [WORD_W-1:0] raw;
    pte_t              pte;
  } mem_word_u;

  typedef struct packed {
    logic              store;
    vaddr_t            vaddr;
    logic [WORD_W-1:0] data;
  } mem_cmd_t;

  typedef struct packed {
    logic              fault;
    logic [WORD_W-1:0] data;
  } mem_resp_t;

endpackage

/* cmd_fifo.sv */
module cmd_fifo
  import mmu_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     push_i,
  input  mem_cmd_t cmd_i,
  input  logic     pop_i,
  output logic     valid_o,
  output mem_cmd_t cmd_o,
  output logic     credit_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  mem_cmd_t         mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;

  assign full    = (count_q == CNT_W'(FIFO_DEPTH));
  assign valid_o = (count_q != '0);
  assign cmd_o   = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= cmd_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + CNT_W'(push_i) - CNT_W'(pop_i);
      // One credit back per freed slot
      credit_o <= pop_i;
    end
  end

  // Sender must respect the credit count
  a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i) push_i |-> !full)
    else $error("push into full command queue");

endmodule

/* dtlb.sv */
module dtlb
  import mmu_pkg::*;
#(
  parameter int TLB_ENTRIES = 4
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               flush_i,
  input  logic [2*VPN_W-1:0] lookup_tag_i,
  output logic               hit_o,
  output tlb_entry_t         entry_o,
  input  logic               fill_v_i,
  input  tlb_entry_t         fill_entry_i
);

  localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

  tlb_entry_t             entries_q [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0] valid_q;
  logic [TLB_ENTRIES-1:0] hit_vec;
  logic [IDX_W-1:0]       rr_q;

  always_comb begin
    entry_o = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      hit_vec[i] = valid_q[i] && (entries_q[i].tag == lookup_tag_i);
      if (hit_vec[i]) begin
        entry_o = entries_q[i];
      end
    end
  end

  assign hit_o = |hit_vec;

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      entries_q[rr_q] <= fill_entry_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
      rr_q    <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (fill_v_i) begin
      valid_q[rr_q] <= 1'b1;
      // Round-robin victim
      rr_q <= (rr_q == IDX_W'(TLB_ENTRIES - 1)) ? '0 : rr_q + 1'b1;
    end
  end

  // A fill only follows a miss, so tags stay unique
  a_one_hit: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(hit_vec))
    else $error("multiple TLB hits");

endmodule

/* page_walker.sv */
module page_walker
  import mmu_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               start_i,
  input  logic [2*VPN_W-1:0] tag_i,
  input  logic [PPN_W-1:0]   root_ppn_i,
  output logic               busy_o,
  output logic [PA_W-1:0]    mem_addr_o,
  input  mem_word_u          mem_rdata_i,
  output logic               fill_v_o,
  output tlb_entry_t         fill_entry_o,
  output logic               done_o,
  output logic               fault_o
);

  typedef enum logic [2:0] {
    e_idle,
    e_l1_rd,
    e_l1_chk,
    e_l0_rd,
    e_l0_chk
  } walk_state_e;

  walk_state_e        state_q;
  logic [2*VPN_W-1:0] tag_q;
  logic [PPN_W-1:0]   ppn_q;
  pte_t               pte;
  logic               l1_ok;
  logic               l0_ok;

  assign pte = mem_rdata_i.pte;

  // Level 1 must point onward, level 0 must be a readable leaf
  assign l1_ok = pte.valid && !pte.read && !pte.write;
  assign l0_ok = pte.valid && pte.read;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= e_idle;
    end else begin
      case (state_q)
        e_idle:   state_q <= start_i ? e_l1_rd : e_idle;
        e_l1_rd:  state_q <= e_l1_chk;
        e_l1_chk: state_q <= l1_ok ? e_l0_rd : e_idle;
        e_l0_rd:  state_q <= e_l0_chk;
        default:  state_q <= e_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      tag_q <= tag_i;
    end
    if (state_q == e_l1_chk) begin
      ppn_q <= pte.ppn;
    end
  end

  assign mem_addr_o = (state_q == e_l0_rd) ?
                      {ppn_q, {(OFFS_W - VPN_W){1'b0}}, tag_q[VPN_W-1:0]} :
                      {root_ppn_i, {(OFFS_W - VPN_W){1'b0}}, tag_q[2*VPN_W-1:VPN_W]};

  assign busy_o   = (state_q != e_idle);
  assign done_o   = ((state_q == e_l1_chk) && !l1_ok) || (state_q == e_l0_chk);
  assign fault_o  = ((state_q == e_l1_chk) && !l1_ok) || ((state_q == e_l0_chk) && !l0_ok);
  assign fill_v_o = (state_q == e_l0_chk) && l0_ok;

  assign fill_entry_o = '{tag: tag_q, ppn: pte.ppn, user: pte.user,
                          write: pte.write, dirty: pte.dirty};

  a_start_idle: assert property (@(posedge clk_i) disable iff (reset_i) start_i |-> !busy_o)
    else $error("walk started while busy");

endmodule

/* phys_mem.sv */
module phys_mem
  import mmu_pkg::*;
(
  input  logic            clk_i,
  input  logic [PA_W-1:0] addr_i,
  input  logic            we_i,
  input  mem_word_u       wdata_i,
  output mem_word_u       rdata_o
);

  mem_word_u mem_q [2**PA_W];

  // Read returns the old word on a write cycle
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    rdata_o <= mem_q[addr_i];
  end

endmodule

/* access_unit.sv */
module access_unit
  import mmu_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               cmd_v_i,
  input  mem_cmd_t           cmd_i,
  output logic               pop_o,
  input  logic               translation_en_i,
  input  priv_e              priv_i,
  input  logic               sum_i,
  input  logic               flush_i,
  input  logic               tlb_hit_i,
  input  tlb_entry_t         tlb_entry_i,
  output logic [2*VPN_W-1:0] lookup_tag_o,
  output logic               walk_start_o,
  input  logic               walk_busy_i,
  input  logic               walk_done_i,
  input  logic               walk_fault_i,
  input  logic [PA_W-1:0]    walk_addr_i,
  output logic [PA_W-1:0]    mem_addr_o,
  output logic               mem_we_o,
  output mem_word_u          mem_wdata_o,
  input  mem_word_u          mem_rdata_i,
  output logic               resp_v_o,
  output mem_resp_t          resp_o
);

  typedef enum logic [2:0] {
    e_idle,
    e_lookup,
    e_walk,
    e_access,
    e_respond
  } seq_state_e;

  seq_state_e      state_q;
  mem_cmd_t        cmd_q;
  logic [PA_W-1:0] pa_q;
  logic            priv_fault;
  logic            perm_fault;

  assign pop_o        = (state_q == e_idle) && cmd_v_i;
  assign lookup_tag_o = {cmd_q.vaddr.vpn1, cmd_q.vaddr.vpn0};
  assign walk_start_o = (state_q == e_lookup) && !tlb_hit_i;

  assign priv_fault = ((priv_i == e_priv_u) && !tlb_entry_i.user) ||
                      ((priv_i == e_priv_s) && tlb_entry_i.user && !sum_i);
  assign perm_fault = priv_fault ||
                      (cmd_q.store && (!tlb_entry_i.write || !tlb_entry_i.dirty));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= e_idle;
    end else begin
      case (state_q)
        e_idle: begin
          if (cmd_v_i) begin
            state_q <= translation_en_i ? e_lookup : e_access;
          end
        end
        e_lookup: begin
          if (!tlb_hit_i) begin
            state_q <= e_walk;
          end else begin
            state_q <= perm_fault ? e_idle : e_access;
          end
        end
        e_walk: begin
          if (walk_done_i) begin
            state_q <= walk_fault_i ? e_idle : e_lookup;
          end
        end
        e_access: state_q <= e_respond;
        default:  state_q <= e_idle;
      endcase
    end
  end

  // Bare mode keeps the low bits, a hit replaces them
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      cmd_q <= cmd_i;
      pa_q  <= cmd_i.vaddr[PA_W-1:0];
    end else if ((state_q == e_lookup) && tlb_hit_i) begin
      pa_q <= {tlb_entry_i.ppn, cmd_q.vaddr.offs};
    end
  end

  // Walker owns the port while busy
  assign mem_addr_o      = walk_busy_i ? walk_addr_i : pa_q;
  assign mem_we_o        = !walk_busy_i && (state_q == e_access) && cmd_q.store;
  assign mem_wdata_o.raw = cmd_q.data;

  always_comb begin
    resp_v_o = 1'b0;
    resp_o   = '0;
    case (state_q)
      e_lookup: begin
        if (tlb_hit_i && perm_fault) begin
          resp_v_o     = 1'b1;
          resp_o.fault = 1'b1;
        end
      end
      e_walk: begin
        if (walk_done_i && walk_fault_i) begin
          resp_v_o     = 1'b1;
          resp_o.fault = 1'b1;
        end
      end
      e_respond: begin
        resp_v_o    = 1'b1;
        resp_o.data = cmd_q.store ? '0 : mem_rdata_i.raw;
      end
      default: begin
        resp_v_o = 1'b0;
      end
    endcase
  end

  // Flush only between commands
  a_flush_idle: assert property (@(posedge clk_i) disable iff (reset_i)
                                 flush_i |-> (state_q == e_idle) && !walk_busy_i)
    else $error("TLB flush during a command");

endmodule

/* mmu_top.sv */
module mmu_top
  import mmu_pkg::*;
#(
  parameter int FIFO_DEPTH  = 4,
  parameter int TLB_ENTRIES = 4
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             cmd_v_i,
  input  mem_cmd_t         cmd_i,
  output logic             cmd_credit_o,
  input  logic             translation_en_i,
  input  logic [PPN_W-1:0] root_ppn_i,
  input  priv_e            priv_i,
  input  logic             sum_i,
  input  logic             flush_i,
  output logic             resp_v_o,
  output mem_resp_t        resp_o
);

  logic               q_valid;
  mem_cmd_t           q_cmd;
  logic               q_pop;
  logic               tlb_hit;
  tlb_entry_t         tlb_entry;
  logic [2*VPN_W-1:0] lookup_tag;
  logic               walk_start;
  logic               walk_busy;
  logic               walk_done;
  logic               walk_fault;
  logic [PA_W-1:0]    walk_addr;
  logic               fill_v;
  tlb_entry_t         fill_entry;
  logic [PA_W-1:0]    mem_addr;
  logic               mem_we;
  mem_word_u          mem_wdata;
  mem_word_u          mem_rdata;

  cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_cmd_fifo (
    .clk_i, .reset_i, .push_i(cmd_v_i), .cmd_i,
    .pop_i(q_pop), .valid_o(q_valid), .cmd_o(q_cmd), .credit_o(cmd_credit_o)
  );

  access_unit u_access_unit (
    .clk_i, .reset_i, .cmd_v_i(q_valid), .cmd_i(q_cmd), .pop_o(q_pop),
    .translation_en_i, .priv_i, .sum_i, .flush_i,
    .tlb_hit_i(tlb_hit), .tlb_entry_i(tlb_entry), .lookup_tag_o(lookup_tag),
    .walk_start_o(walk_start), .walk_busy_i(walk_busy), .walk_done_i(walk_done),
    .walk_fault_i(walk_fault), .walk_addr_i(walk_addr),
    .mem_addr_o(mem_addr), .mem_we_o(mem_we), .mem_wdata_o(mem_wdata),
    .mem_rdata_i(mem_rdata), .resp_v_o, .resp_o
  );

  dtlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_dtlb (
    .clk_i, .reset_i, .flush_i, .lookup_tag_i(lookup_tag),
    .hit_o(tlb_hit), .entry_o(tlb_entry), .fill_v_i(fill_v), .fill_entry_i(fill_entry)
  );

  page_walker u_page_walker (
    .clk_i, .reset_i, .start_i(walk_start), .tag_i(lookup_tag), .root_ppn_i,
    .busy_o(walk_busy), .mem_addr_o(walk_addr), .mem_rdata_i(mem_rdata),
    .fill_v_o(fill_v), .fill_entry_o(fill_entry), .done_o(walk_done), .fault_o(walk_fault)
  );

  phys_mem u_phys_mem (
    .clk_i, .addr_i(mem_addr), .we_i(mem_we), .wdata_i(mem_wdata), .rdata_o(mem_rdata)
  );

endmodule

/* tb_clkgen.sv */
module tb_clkgen #(
  parameter int PERIOD = 20
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2) clk_o = ~clk_o;
    end
  end

endmodule

/* tb_mmu.sv */
module tb_mmu
  import mmu_pkg::*;
();

  localparam int FIFO_DEPTH  = 4;
  localparam int TLB_ENTRIES = 4;
  localparam int N_FILL      = 2 ** PA_W;
  localparam int N_BARE      = 200;
  localparam int N_PT        = 48;
  localparam int N_XLAT      = 150;
  localparam int N_REMAP     = 60;
  localparam int N_TOTAL     = N_FILL + N_BARE + N_PT + 4 * N_XLAT + N_REMAP + 2;

  logic             clk;
  logic             reset;
  logic             cmd_v;
  mem_cmd_t         cmd;
  logic             cmd_credit;
  logic             xlat_en;
  logic [PPN_W-1:0] root_ppn;
  priv_e            priv;
  logic             sum;
  logic             flush;
  logic             resp_v;
  mem_resp_t        resp;

  logic [WORD_W-1:0] model_mem [2**PA_W];
  mem_resp_t         exp_q [$];
  logic [31:0]       seed;
  int                sent_cnt;
  int                credit_pulses;

  tb_clkgen #(.PERIOD(20)) u_clkgen (.clk_o(clk));

  mmu_top #(.FIFO_DEPTH(FIFO_DEPTH), .TLB_ENTRIES(TLB_ENTRIES)) i_dut (
    .clk_i(clk), .reset_i(reset), .cmd_v_i(cmd_v), .cmd_i(cmd), .cmd_credit_o(cmd_credit),
    .translation_en_i(xlat_en), .root_ppn_i(root_ppn), .priv_i(priv), .sum_i(sum),
    .flush_i(flush), .resp_v_o(resp_v), .resp_o(resp)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_resp(input mem_resp_t got, input mem_resp_t exp);
    if (got !== exp) begin
      fail_now($sformatf("Fail resp_o: got %h expected %h", got, exp));
    end
  endtask

  task automatic check_credits(input string name, input int got, input int exp);
    if (got != exp) begin
      fail_now($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
  endtask

  function automatic logic [WORD_W-1:0] make_pte(input logic v, rd, wr, u, d,
                                                 input logic [PPN_W-1:0] ppn);
    pte_t p;
    p       = '0;
    p.valid = v;
    p.read  = rd;
    p.write = wr;
    p.user  = u;
    p.dirty = d;
    p.ppn   = ppn;
    return p;
  endfunction

  // Reference walk, permission check and word access
  function automatic mem_resp_t model_access(input mem_cmd_t c);
    mem_resp_t       r;
    pte_t            l1;
    pte_t            l0;
    logic [PA_W-1:0] pa;
    logic            fault;
    r     = '0;
    fault = 1'b0;
    pa    = c.vaddr[PA_W-1:0];
    if (xlat_en) begin
      l1 = model_mem[int'(root_ppn) * 64 + int'(c.vaddr.vpn1)];
      l0 = model_mem[int'(l1.ppn) * 64 + int'(c.vaddr.vpn0)];
      if (!l1.valid || l1.read || l1.write) begin
        fault = 1'b1;
      end else if (!l0.valid || !l0.read) begin
        fault = 1'b1;
      end else if ((priv == e_priv_u) && !l0.user) begin
        fault = 1'b1;
      end else if ((priv == e_priv_s) && l0.user && !sum) begin
        fault = 1'b1;
      end else if (c.store && (!l0.write || !l0.dirty)) begin
        fault = 1'b1;
      end
      pa = {l0.ppn, c.vaddr.offs};
    end
    if (fault) begin
      r.fault = 1'b1;
    end else if (c.store) begin
      model_mem[pa] = c.data;
    end else begin
      r.data = model_mem[pa];
    end
    return r;
  endfunction

  // Entered and left at 2 units after a rising edge
  task automatic send_cmd(input logic store, input logic [VA_W-1:0] va,
                          input logic [WORD_W-1:0] data);
    mem_cmd_t c;
    c.store = store;
    c.vaddr = va;
    c.data  = data;
    while (FIFO_DEPTH - sent_cnt + credit_pulses <= 0) begin
      @(posedge clk);
      #2;
    end
    cmd_v = 1'b1;
    cmd   = c;
    sent_cnt++;
    exp_q.push_back(model_access(c));
    @(posedge clk);
    #2;
    cmd_v = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #2;
    end
    repeat (2) begin
      @(posedge clk);
      #2;
    end
  endtask

  function automatic logic [WORD_W-1:0] l1_entry(input int i);
    logic [WORD_W-1:0] w;
    case (i)
      0:       w = make_pte(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 4'd1);
      1:       w = make_pte(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 4'd2);
      3:       w = make_pte(1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 4'd4);
      default: w = next_rand() & 32'h7fff_ffff;
    endcase
    return w;
  endfunction

  // User pages where pairs share a physical page
  function automatic logic [WORD_W-1:0] l0_user_entry(input int i);
    logic [WORD_W-1:0] w;
    if (i < 8) begin
      w = make_pte(1'b1, 1'b1, 1'b1, 1'b1, 1'b1, PPN_W'(4 + i / 2));
    end else if (i == 9) begin
      w = make_pte(1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 4'd8);
    end else if (i == 10) begin
      w = make_pte(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 4'd8);
    end else if (i == 11) begin
      w = make_pte(1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 4'd8);
    end else begin
      w = next_rand() & 32'h7fff_ffff;
    end
    return w;
  endfunction

  function automatic logic [WORD_W-1:0] l0_sup_entry(input int i);
    logic [WORD_W-1:0] w;
    if (i < 4) begin
      w = make_pte(1'b1, 1'b1, 1'b1, 1'b0, 1'b1, PPN_W'(9 + i));
    end else if (i == 4) begin
      w = make_pte(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 4'd13);
    end else begin
      w = next_rand() & 32'h7fff_ffff;
    end
    return w;
  endfunction

  task automatic run_translated(input priv_e p, input logic s, input int n,
                                input int vpn1_mod, input int vpn0_mod);
    logic [31:0] r;
    vaddr_t      va;
    priv    = p;
    sum     = s;
    xlat_en = 1'b1;
    repeat (n) begin
      // Upper LCG bits have the longest periods
      r       = next_rand();
      va.vpn1 = VPN_W'(int'(r[31:28]) % vpn1_mod);
      va.vpn0 = VPN_W'(int'(r[27:24]) % vpn0_mod);
      va.offs = r[21:16];
      send_cmd(r[23], va, next_rand());
    end
    drain();
  endtask

  // Responses and credits sampled mid-cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (cmd_credit) begin
        credit_pulses++;
        if (credit_pulses > sent_cnt) begin
          fail_now("More credits returned than commands sent");
        end
      end
      if (resp_v) begin
        if (exp_q.size() == 0) begin
          fail_now("Response arrived with no command outstanding");
        end else begin
          check_resp(resp, exp_q.pop_front());
        end
      end
    end
  end

  initial begin
    repeat (200 * N_TOTAL) @(posedge clk);
    $display("Timeout: the DUT stopped answering commands");
    $display("TB FAILED");
    $fatal(1);
  end

  initial begin
    logic [31:0] r;
    seed          = 32'h9460;
    sent_cnt      = 0;
    credit_pulses = 0;
    reset         = 1'b1;
    cmd_v         = 1'b0;
    cmd           = '0;
    xlat_en       = 1'b0;
    root_ppn      = '0;
    priv          = e_priv_m;
    sum           = 1'b0;
    flush         = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    if (cmd_credit || resp_v) begin
      fail_now("Credit or response active right after reset");
    end

    // Fill pattern covers the whole address
    for (int a = 0; a < N_FILL; a++) begin
      send_cmd(1'b1, VA_W'(a), {PA_W'(a), 12'h5a3, PA_W'(a)});
    end
    repeat (N_BARE) begin
      r = next_rand();
      send_cmd(r[20], r[VA_W-1:0], next_rand());
    end
    drain();

    // Page tables with the root in page 0
    for (int i = 0; i < 16; i++) begin
      send_cmd(1'b1, VA_W'(i), l1_entry(i));
      send_cmd(1'b1, VA_W'(64 + i), l0_user_entry(i));
      send_cmd(1'b1, VA_W'(128 + i), l0_sup_entry(i));
    end
    drain();

    run_translated(e_priv_u, 1'b0, N_XLAT, 4, 12);
    run_translated(e_priv_s, 1'b0, N_XLAT, 4, 12);
    run_translated(e_priv_s, 1'b1, N_XLAT, 4, 12);
    run_translated(e_priv_m, 1'b0, N_XLAT, 4, 12);

    // Cache the old mapping, then move it
    run_translated(e_priv_u, 1'b0, 0, 1, 1);
    send_cmd(1'b0, VA_W'(5), '0);
    drain();
    xlat_en = 1'b0;
    send_cmd(1'b1, VA_W'(64), make_pte(1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 4'd14));
    drain();
    flush = 1'b1;
    @(posedge clk);
    #2;
    flush = 1'b0;
    run_translated(e_priv_u, 1'b0, N_REMAP, 1, 4);

    check_credits("cmd_credit_o pulses", credit_pulses, sent_cnt);
    $display("TB PASSED");
    $finish;
  end

endmodule

/* build.f */
mmu_pkg.sv
cmd_fifo.sv
dtlb.sv
page_walker.sv
phys_mem.sv
access_unit.sv
mmu_top.sv
tb_clkgen.sv
tb_mmu.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f build.f --top-module tb_mmu -o tb_mmu_sim; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/tb_mmu_sim > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" sim.log; then
  exit 0
fi
exit 1
